// ==== matrix_calc.f ====
matrix_pkg.sv
ctrl_pkg.sv
mode_fsm.sv
elem_walker.sv
matrix_store.sv
matrix_alu.sv
matrix_calc_top.sv
tb_matrix_calc.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLIST     ?= matrix_calc.f
TB_TOP    ?= tb_matrix_calc
RTL_TOP   ?= matrix_calc_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= TB PASSED
VFLAGS    ?= --timing --assert --timescale 1ns/100ps -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TB_TOP) \
		--Mdir $(BUILD_DIR) -o V$(TB_TOP)
	$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb_matrix_calc.sv ====
module tb_matrix_calc;
  timeunit 1ns;
  timeprecision 100ps;

  // Full sequence takes a few hundred cycles so this leaves wide margin
  localparam int TIMEOUT_CYCLES = 4000;

  logic              clk;
  logic              rst_n;
  logic [7:0]        rx_byte;
  logic              rx_valid;
  logic              btn_input;
  logic              btn_confirm;
  logic              btn_esc;
  ctrl_pkg::op_req_t req;
  logic              tx_ready;
  logic [7:0]        tx_byte;
  logic              tx_valid;
  logic [7:0]        led_status;

  // Reference copy of the slot store
  matrix_pkg::elem_t m_data [matrix_pkg::NUM_SLOTS][matrix_pkg::MAX_DIM][matrix_pkg::MAX_DIM];
  int                m_rows [matrix_pkg::NUM_SLOTS];
  int                m_cols [matrix_pkg::NUM_SLOTS];
  bit                m_valid [matrix_pkg::NUM_SLOTS];
  int                m_wr_ptr;

  logic [7:0] exp_q[$];
  bit         quiet;
  bit         hold_prev;
  logic [7:0] prev_byte;
  int         mism_cnt;
  int         fail_cnt;
  int         byte_cnt;
  int         cycles;
  integer     seed;

  matrix_calc_top i_dut (
    .clk(clk), .rst_n(rst_n), .rx_byte(rx_byte), .rx_valid(rx_valid),
    .btn_input(btn_input), .btn_confirm(btn_confirm), .btn_esc(btn_esc),
    .req(req), .tx_ready(tx_ready), .tx_byte(tx_byte), .tx_valid(tx_valid),
    .led_status(led_status)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Random back-pressure, ready about three cycles in four
  initial begin
    seed     = 32'h2244dfe0;
    tx_ready = 1'b0;
    forever begin
      @(negedge clk);
      tx_ready = ($random(seed) % 4) != 0;
    end
  end

  // ==========================================================
  // Output checks
  // ==========================================================
  always @(posedge clk) begin
    if (rst_n) begin
      // Held byte must survive a stalled cycle
      if (hold_prev) begin
        assert (tx_valid) else begin
          fail_cnt++;
          $display("tx_valid dropped at %0d ns while tx_ready was low", $time);
        end
        assert (tx_byte == prev_byte) else begin
          mism_cnt++;
          $display("mismatch at %0d ns: tx_byte expected %02h got %02h while held",
                   $time, prev_byte, tx_byte);
        end
      end
      if (quiet) begin
        assert (!tx_valid) else begin
          fail_cnt++;
          $display("tx_valid high at %0d ns with no result expected", $time);
        end
      end
      if (tx_valid && tx_ready) begin
        assert (exp_q.size() != 0) else begin
          fail_cnt++;
          $display("extra byte %02h sent at %0d ns", tx_byte, $time);
        end
        if (exp_q.size() != 0) begin
          assert (tx_byte == exp_q[0]) else begin
            mism_cnt++;
            $display("mismatch at %0d ns: tx_byte expected %02h got %02h",
                     $time, exp_q[0], tx_byte);
          end
          void'(exp_q.pop_front());
          byte_cnt++;
        end
      end
      hold_prev = tx_valid && !tx_ready;
      prev_byte = tx_byte;
    end
  end

  function automatic void print_counts();
    $display("%0d mismatches, %0d other errors, %0d bytes checked",
             mism_cnt, fail_cnt, byte_cnt);
  endfunction

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      fail_cnt++;
      $display("timeout after %0d cycles, sequence did not finish", cycles);
      print_counts();
      $display("TB FAILED");
      $finish;
    end
  end

  // ==========================================================
  // Stimulus tasks, each entered and left at a falling edge
  // ==========================================================
  task automatic check_leds(input logic [7:0] expected);
    assert (led_status == expected) else begin
      mism_cnt++;
      $display("mismatch at %0d ns: led_status expected %02h got %02h",
               $time, expected, led_status);
    end
  endtask

  task automatic send_byte(input logic [7:0] value);
    rx_byte  = value;
    rx_valid = 1'b1;
    @(negedge clk);
    rx_valid = 1'b0;
  endtask

  // Starting an entry drops the target slot
  task automatic start_entry();
    m_valid[m_wr_ptr] = 1'b0;
    btn_input = 1'b1;
    @(negedge clk);
    btn_input = 1'b0;
    // Entering with the error flag cleared
    check_leds(8'h02);
  endtask

  // Element k of the matrix is base + k * step, wrapped to 8 bits
  task automatic enter_matrix(input int rows, input int cols, input int base, input int step);
    start_entry();
    send_byte(8'(rows));
    send_byte(8'(cols));
    for (int k = 0; k < rows * cols; k++) begin
      send_byte(8'(base + k * step));
      m_data[m_wr_ptr][k / cols][k % cols] = matrix_pkg::elem_t'(base + k * step);
    end
    m_rows[m_wr_ptr]  = rows;
    m_cols[m_wr_ptr]  = cols;
    m_valid[m_wr_ptr] = 1'b1;
    m_wr_ptr          = (m_wr_ptr + 1) % matrix_pkg::NUM_SLOTS;
    check_leds(8'h01);
  endtask

  // Escape after one element, pointer stays put
  task automatic abort_entry();
    start_entry();
    send_byte(8'd2);
    send_byte(8'd2);
    send_byte(8'h55);
    btn_esc = 1'b1;
    @(negedge clk);
    btn_esc = 1'b0;
    check_leds(8'h01);
  endtask

  task automatic enter_bad_rows();
    start_entry();
    send_byte(8'd5);
    check_leds(8'h81);
  endtask

  function automatic bit is_legal(input ctrl_pkg::op_e code, input int a, input int b);
    if (!m_valid[a]) return 1'b0;
    if (code != ctrl_pkg::OP_ADD) return 1'b1;
    return m_valid[b] && m_rows[a] == m_rows[b] && m_cols[a] == m_cols[b];
  endfunction

  // Header then each result element high byte first
  function automatic void queue_result(input ctrl_pkg::op_e code, input int a, input int b,
                                       input int s);
    int          rows;
    int          cols;
    int          v;
    logic [15:0] w;
    rows = (code == ctrl_pkg::OP_TRANSPOSE) ? m_cols[a] : m_rows[a];
    cols = (code == ctrl_pkg::OP_TRANSPOSE) ? m_rows[a] : m_cols[a];
    exp_q.push_back(8'(rows));
    exp_q.push_back(8'(cols));
    for (int r = 0; r < rows; r++) begin
      for (int c = 0; c < cols; c++) begin
        v = (code == ctrl_pkg::OP_TRANSPOSE) ? m_data[a][c][r] : m_data[a][r][c];
        if (code == ctrl_pkg::OP_ADD) v = v + m_data[b][r][c];
        if (code == ctrl_pkg::OP_SCALE) v = v * s;
        w = 16'(v);
        exp_q.push_back(w[15:8]);
        exp_q.push_back(w[7:0]);
      end
    end
  endfunction

  task automatic run_op(input ctrl_pkg::op_e code, input int a, input int b, input int s,
                        input bit timing);
    bit ok;
    ok = is_legal(code, a, b);
    if (ok) begin
      queue_result(code, a, b, s);
      quiet = 1'b0;
    end
    req = '{op: code, id_a: matrix_pkg::SLOT_W'(a), id_b: matrix_pkg::SLOT_W'(b),
            scalar: matrix_pkg::elem_t'(s)};
    btn_confirm = 1'b1;
    @(negedge clk);
    btn_confirm = 1'b0;
    if (timing) begin
      assert (!tx_valid) else begin
        fail_cnt++;
        $display("tx_valid rose one cycle after confirm at %0d ns", $time);
      end
      @(negedge clk);
      assert (tx_valid) else begin
        fail_cnt++;
        $display("tx_valid not high two cycles after confirm at %0d ns", $time);
      end
      // Sending shows on its own status bit
      check_leds(8'h04);
    end
    do @(negedge clk); while (!led_status[0]);
    quiet = 1'b1;
    assert (exp_q.size() == 0) else begin
      fail_cnt++;
      $display("%0d expected bytes never sent before %0d ns", exp_q.size(), $time);
    end
    exp_q.delete();
    check_leds(ok ? 8'h01 : 8'h81);
  endtask

  // ==========================================================
  // Test sequence
  // ==========================================================
  initial begin
    rst_n       = 1'b0;
    rx_byte     = 8'h00;
    rx_valid    = 1'b0;
    btn_input   = 1'b0;
    btn_confirm = 1'b0;
    btn_esc     = 1'b0;
    req         = '0;
    quiet       = 1'b1;
    m_wr_ptr    = 0;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_leds(8'h01);

    // Slots 0 and 1 shaped 2x3 and 3x2
    enter_matrix(2, 3, -3, 45);
    enter_matrix(3, 2, 100, -70);
    run_op(ctrl_pkg::OP_SHOW, 0, 0, 0, 1'b0);
    run_op(ctrl_pkg::OP_SHOW, 1, 0, 0, 1'b0);

    // Slot 2 matches slot 0 in shape
    enter_matrix(2, 3, 127, 31);
    run_op(ctrl_pkg::OP_ADD, 0, 2, 0, 1'b1);
    run_op(ctrl_pkg::OP_TRANSPOSE, 0, 0, 0, 1'b0);

    // Slot 3 starts with -128
    enter_matrix(2, 2, -128, 127);
    run_op(ctrl_pkg::OP_SCALE, 3, 0, -128, 1'b0);
    run_op(ctrl_pkg::OP_SCALE, 0, 0, -7, 1'b0);

    // Error cases
    run_op(ctrl_pkg::OP_ADD, 0, 1, 0, 1'b0);
    abort_entry();
    run_op(ctrl_pkg::OP_SHOW, 0, 0, 0, 1'b0);
    enter_bad_rows();

    // Fifth full entry lands in slot 0
    enter_matrix(4, 4, 9, -17);
    run_op(ctrl_pkg::OP_SHOW, 0, 0, 0, 1'b0);
    run_op(ctrl_pkg::OP_TRANSPOSE, 0, 0, 0, 1'b0);
    run_op(ctrl_pkg::OP_SHOW, 1, 0, 0, 1'b0);

    repeat (2) @(negedge clk);
    print_counts();
    if (mism_cnt == 0 && fail_cnt == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== matrix_calc_top.sv ====
module matrix_calc_top (
  input  logic              clk,
  input  logic              rst_n,
  input  logic [7:0]        rx_byte,
  input  logic              rx_valid,
  input  logic              btn_input,
  input  logic              btn_confirm,
  input  logic              btn_esc,
  input  ctrl_pkg::op_req_t req,
  input  logic              tx_ready,
  output logic [7:0]        tx_byte,
  output logic              tx_valid,
  output logic [7:0]        led_status
);

  // ==========================================================
  // Interconnect
  // ==========================================================
  ctrl_pkg::state_e              state;
  ctrl_pkg::op_req_t             op;
  logic                          err;
  logic                          walk_clear, walk_step, walk_last, half;
  matrix_pkg::dims_t             walk_dims, wr_dims, res_dims;
  logic [matrix_pkg::DIM_W-1:0]  row, col, rd_row, rd_col;
  logic                          wr_en, wr_commit;
  logic [matrix_pkg::SLOT_W-1:0] wr_slot;
  matrix_pkg::elem_t             rd_a, rd_b;
  matrix_pkg::dims_t             dims_a, dims_b;
  logic                          valid_a, valid_b, op_ok;
  matrix_pkg::result_t           result;
  logic                          entering;

  assign entering = (state == ctrl_pkg::ST_IN_ROWS) || (state == ctrl_pkg::ST_IN_COLS) ||
                    (state == ctrl_pkg::ST_IN_ELEM);
  assign tx_valid = (state == ctrl_pkg::ST_SEND_HEAD) || (state == ctrl_pkg::ST_SEND_ELEM);

  mode_fsm u_fsm (
    .clk(clk), .rst_n(rst_n), .rx_valid(rx_valid), .rx_byte(rx_byte),
    .btn_input(btn_input), .btn_confirm(btn_confirm), .btn_esc(btn_esc),
    .req(req), .tx_ready(tx_ready), .op_ok(op_ok), .res_dims(res_dims),
    .walk_last(walk_last), .walk_clear(walk_clear), .walk_step(walk_step),
    .walk_dims(walk_dims), .wr_en(wr_en), .wr_slot(wr_slot), .wr_dims(wr_dims),
    .wr_commit(wr_commit), .op(op), .state(state), .err(err)
  );

  // Byte halves only counted while sending
  elem_walker u_walker (
    .clk(clk), .rst_n(rst_n), .clear(walk_clear), .step(walk_step),
    .dims(walk_dims), .half_en(tx_valid),
    .row(row), .col(col), .half(half), .last(walk_last)
  );

  // Entry writes at the walker position; reads follow the ALU mapping
  matrix_store u_store (
    .clk(clk), .rst_n(rst_n), .wr_en(wr_en),
    .wr_addr('{slot: wr_slot, row: row, col: col}),
    .wr_data(matrix_pkg::elem_t'(rx_byte)), .wr_commit(wr_commit), .wr_dims(wr_dims),
    .rd_addr_a('{slot: op.id_a, row: rd_row, col: rd_col}),
    .rd_addr_b('{slot: op.id_b, row: rd_row, col: rd_col}),
    .rd_a(rd_a), .rd_b(rd_b), .dims_a(dims_a), .dims_b(dims_b),
    .valid_a(valid_a), .valid_b(valid_b)
  );

  matrix_alu u_alu (
    .op(op), .a(rd_a), .b(rd_b), .dims_a(dims_a), .dims_b(dims_b),
    .valid_a(valid_a), .valid_b(valid_b), .row(row), .col(col),
    .rd_row(rd_row), .rd_col(rd_col), .result(result), .res_dims(res_dims), .op_ok(op_ok)
  );

  // Header rows then cols, elements high byte first
  always_comb begin
    case (state)
      ctrl_pkg::ST_SEND_HEAD: tx_byte = half ? 8'(res_dims.cols) : 8'(res_dims.rows);
      ctrl_pkg::ST_SEND_ELEM: tx_byte = half ? result[7:0] : result[15:8];
      default:                tx_byte = 8'h00;
    endcase
  end

  // Idle, entering, sending, error
  assign led_status = {err, 4'b0000, tx_valid, entering, state == ctrl_pkg::ST_IDLE};

endmodule

// ==== matrix_alu.sv ====
module matrix_alu (
  input  ctrl_pkg::op_req_t              op,
  input  matrix_pkg::elem_t              a,
  input  matrix_pkg::elem_t              b,
  input  matrix_pkg::dims_t              dims_a,
  input  matrix_pkg::dims_t              dims_b,
  input  logic                           valid_a,
  input  logic                           valid_b,
  input  logic [matrix_pkg::DIM_W-1:0]   row,
  input  logic [matrix_pkg::DIM_W-1:0]   col,
  output logic [matrix_pkg::DIM_W-1:0]   rd_row,
  output logic [matrix_pkg::DIM_W-1:0]   rd_col,
  output matrix_pkg::result_t            result,
  output matrix_pkg::dims_t              res_dims,
  output logic                           op_ok
);

  logic is_trans;

  // Widen with sign
  function automatic matrix_pkg::result_t sext(input matrix_pkg::elem_t v);
    return matrix_pkg::result_t'(v);
  endfunction

  assign is_trans = (op.op == ctrl_pkg::OP_TRANSPOSE);

  // Result position maps back to operand position
  assign rd_row = is_trans ? col : row;
  assign rd_col = is_trans ? row : col;

  // Transpose swaps the shape, others keep A's
  assign res_dims = is_trans ? matrix_pkg::dims_t'{rows: dims_a.cols, cols: dims_a.rows}
                             : dims_a;

  // A must exist; add also needs B of the same shape
  always_comb begin
    op_ok = valid_a;
    if (op.op == ctrl_pkg::OP_ADD) op_ok = valid_a && valid_b && (dims_a == dims_b);
  end

  // Per-element arithmetic
  always_comb begin
    case (op.op)
      ctrl_pkg::OP_ADD:   result = sext(a) + sext(b);
      // -128 * -128 still fits in 16 bits
      ctrl_pkg::OP_SCALE: result = sext(a) * sext(op.scalar);
      default:            result = sext(a);
    endcase
  end

endmodule

// ==== matrix_store.sv ====
module matrix_store (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   wr_en,
  input  matrix_pkg::elem_addr_t wr_addr,
  input  matrix_pkg::elem_t      wr_data,
  input  logic                   wr_commit,
  input  matrix_pkg::dims_t      wr_dims,
  input  matrix_pkg::elem_addr_t rd_addr_a,
  input  matrix_pkg::elem_addr_t rd_addr_b,
  output matrix_pkg::elem_t      rd_a,
  output matrix_pkg::elem_t      rd_b,
  output matrix_pkg::dims_t      dims_a,
  output matrix_pkg::dims_t      dims_b,
  output logic                   valid_a,
  output logic                   valid_b
);

  // Index bits actually needed inside one matrix
  localparam int IDX_W = $clog2(matrix_pkg::MAX_DIM);

  matrix_pkg::elem_t mem    [matrix_pkg::NUM_SLOTS][matrix_pkg::MAX_DIM][matrix_pkg::MAX_DIM];
  matrix_pkg::dims_t dims_q [matrix_pkg::NUM_SLOTS];
  logic [matrix_pkg::NUM_SLOTS-1:0] valid_q;

  // ==========================================================
  // Element array
  // ==========================================================
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr.slot][wr_addr.row[IDX_W-1:0]][wr_addr.col[IDX_W-1:0]] <= wr_data;
    end
  end

  // ==========================================================
  // Slot dims and valid bits
  // ==========================================================
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else begin
      // Any write marks the slot incomplete
      if (wr_en) valid_q[wr_addr.slot] <= 1'b0;
      // Commit comes with the last element and overrides the clear
      if (wr_commit) begin
        valid_q[wr_addr.slot] <= 1'b1;
        dims_q[wr_addr.slot]  <= wr_dims;
      end
    end
  end

  // Combinational read ports
  assign rd_a = mem[rd_addr_a.slot][rd_addr_a.row[IDX_W-1:0]][rd_addr_a.col[IDX_W-1:0]];
  assign rd_b = mem[rd_addr_b.slot][rd_addr_b.row[IDX_W-1:0]][rd_addr_b.col[IDX_W-1:0]];

  assign dims_a  = dims_q[rd_addr_a.slot];
  assign dims_b  = dims_q[rd_addr_b.slot];
  assign valid_a = valid_q[rd_addr_a.slot];
  assign valid_b = valid_q[rd_addr_b.slot];

endmodule

// ==== elem_walker.sv ====
module elem_walker (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           clear,
  input  logic                           step,
  input  matrix_pkg::dims_t              dims,
  input  logic                           half_en,
  output logic [matrix_pkg::DIM_W-1:0]   row,
  output logic [matrix_pkg::DIM_W-1:0]   col,
  output logic                           half,
  output logic                           last
);

  logic [matrix_pkg::DIM_W-1:0] last_row;
  logic [matrix_pkg::DIM_W-1:0] last_col;
  logic                         elem_end;

  assign last_row = dims.rows - matrix_pkg::DIM_W'(1);
  assign last_col = dims.cols - matrix_pkg::DIM_W'(1);

  // Final byte of an element, low half when halves are counted
  assign elem_end = half || !half_en;
  assign last     = (row == last_row) && (col == last_col) && elem_end;

  // Clear wins over step
  always_ff @(posedge clk) begin
    if (!rst_n || clear) begin
      row  <= '0;
      col  <= '0;
      half <= 1'b0;
    end else if (step) begin
      if (!elem_end) begin
        // High byte done, low byte next
        half <= 1'b1;
      end else begin
        half <= 1'b0;
        if (col == last_col) begin
          col <= '0;
          // Wrap at the end so the next walk starts clean
          row <= (row == last_row) ? '0 : row + matrix_pkg::DIM_W'(1);
        end else begin
          col <= col + matrix_pkg::DIM_W'(1);
        end
      end
    end
  end

endmodule

// ==== mode_fsm.sv ====
module mode_fsm (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            rx_valid,
  input  logic [7:0]                      rx_byte,
  input  logic                            btn_input,
  input  logic                            btn_confirm,
  input  logic                            btn_esc,
  input  ctrl_pkg::op_req_t               req,
  input  logic                            tx_ready,
  input  logic                            op_ok,
  input  matrix_pkg::dims_t               res_dims,
  input  logic                            walk_last,
  output logic                            walk_clear,
  output logic                            walk_step,
  output matrix_pkg::dims_t               walk_dims,
  output logic                            wr_en,
  output logic [matrix_pkg::SLOT_W-1:0]   wr_slot,
  output matrix_pkg::dims_t               wr_dims,
  output logic                            wr_commit,
  output ctrl_pkg::op_req_t               op,
  output ctrl_pkg::state_e                state,
  output logic                            err
);

  logic [matrix_pkg::SLOT_W-1:0] wr_ptr;
  ctrl_pkg::op_req_t             op_q;
  matrix_pkg::dims_t             ent_dims;
  logic                          dim_bad;
  logic                          elem_acc;
  logic                          sending;

  // Dimension byte out of range
  assign dim_bad = (rx_byte == 8'd0) || (rx_byte > 8'(matrix_pkg::MAX_DIM));

  // Element byte taken this cycle
  assign elem_acc = (state == ctrl_pkg::ST_IN_ELEM) && rx_valid && !btn_esc;
  assign sending  = (state == ctrl_pkg::ST_SEND_HEAD) || (state == ctrl_pkg::ST_SEND_ELEM);

  // ==========================================================
  // State, error flag and write pointer
  // ==========================================================
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state  <= ctrl_pkg::ST_IDLE;
      err    <= 1'b0;
      wr_ptr <= '0;
    end else begin
      case (state)
        ctrl_pkg::ST_IDLE: begin
          // Entry wins over an operation in the same cycle
          if (btn_input) begin
            state <= ctrl_pkg::ST_IN_ROWS;
            err   <= 1'b0;
          end else if (btn_confirm) begin
            state <= ctrl_pkg::ST_CHECK;
            err   <= 1'b0;
          end
        end
        ctrl_pkg::ST_IN_ROWS, ctrl_pkg::ST_IN_COLS: begin
          if (btn_esc) begin
            state <= ctrl_pkg::ST_IDLE;
          end else if (rx_valid && dim_bad) begin
            err   <= 1'b1;
            state <= ctrl_pkg::ST_IDLE;
          end else if (rx_valid) begin
            state <= (state == ctrl_pkg::ST_IN_ROWS) ? ctrl_pkg::ST_IN_COLS
                                                     : ctrl_pkg::ST_IN_ELEM;
          end
        end
        ctrl_pkg::ST_IN_ELEM: begin
          if (btn_esc) begin
            state <= ctrl_pkg::ST_IDLE;
          end else if (elem_acc && walk_last) begin
            state  <= ctrl_pkg::ST_IDLE;
            // Wraps modulo NUM_SLOTS
            wr_ptr <= wr_ptr + 1'b1;
          end
        end
        ctrl_pkg::ST_CHECK: begin
          if (op_ok) begin
            state <= ctrl_pkg::ST_SEND_HEAD;
          end else begin
            err   <= 1'b1;
            state <= ctrl_pkg::ST_IDLE;
          end
        end
        ctrl_pkg::ST_SEND_HEAD: begin
          if (tx_ready && walk_last) state <= ctrl_pkg::ST_SEND_ELEM;
        end
        ctrl_pkg::ST_SEND_ELEM: begin
          if (tx_ready && walk_last) state <= ctrl_pkg::ST_IDLE;
        end
        default: state <= ctrl_pkg::ST_IDLE;
      endcase
    end
  end

  // Request and entry dims latches
  always_ff @(posedge clk) begin
    if (state == ctrl_pkg::ST_IDLE && btn_confirm && !btn_input) op_q <= req;
    if (state == ctrl_pkg::ST_IN_ROWS && rx_valid)
      ent_dims.rows <= rx_byte[matrix_pkg::DIM_W-1:0];
    if (state == ctrl_pkg::ST_IN_COLS && rx_valid)
      ent_dims.cols <= rx_byte[matrix_pkg::DIM_W-1:0];
  end

  // ==========================================================
  // Walker and store controls
  // ==========================================================

  // Header walked as a 1x1 matrix of two byte halves
  always_comb begin
    case (state)
      ctrl_pkg::ST_SEND_HEAD: walk_dims = matrix_pkg::dims_t'{rows: 3'd1, cols: 3'd1};
      ctrl_pkg::ST_SEND_ELEM: walk_dims = res_dims;
      default:                walk_dims = ent_dims;
    endcase
  end

  // Held at origin in idle, rewound after the header
  assign walk_clear = (state == ctrl_pkg::ST_IDLE) ||
                      (state == ctrl_pkg::ST_SEND_HEAD && tx_ready && walk_last);
  assign walk_step  = elem_acc || (sending && tx_ready);

  // Start of entry writes too, which drops the slot valid bit
  assign wr_en     = (state == ctrl_pkg::ST_IDLE && btn_input) || elem_acc;
  assign wr_commit = elem_acc && walk_last;
  assign wr_slot   = wr_ptr;
  assign wr_dims   = ent_dims;
  assign op        = op_q;

endmodule

// ==== ctrl_pkg.sv ====
package ctrl_pkg;

  // Controller states
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_IN_ROWS,
    ST_IN_COLS,
    ST_IN_ELEM,
    ST_CHECK,
    ST_SEND_HEAD,
    ST_SEND_ELEM
  } state_e;

  // Operation codes
  typedef enum logic [1:0] {
    OP_SHOW,
    OP_ADD,
    OP_TRANSPOSE,
    OP_SCALE
  } op_e;

  // Operation request, sampled at confirm
  typedef struct packed {
    op_e                             op;
    logic [matrix_pkg::SLOT_W-1:0]   id_a;
    // Second operand, only read by add
    logic [matrix_pkg::SLOT_W-1:0]   id_b;
    // Multiplier for scale
    matrix_pkg::elem_t               scalar;
  } op_req_t;

endpackage

// ==== matrix_pkg.sv ====
package matrix_pkg;

  // ==========================================================
  // Matrix geometry
  // ==========================================================

  // Largest row or column count
  localparam int MAX_DIM = 4;

  // Stored matrices, reused round-robin
  localparam int NUM_SLOTS = 4;

  // Dimension or index width, wide enough to hold MAX_DIM itself
  localparam int DIM_W = 3;

  // Slot id width
  localparam int SLOT_W = 2;

  // ==========================================================
  // Element types
  // ==========================================================

  // Stored element as received
  typedef logic signed [7:0] elem_t;

  // Computed element, holds any product of two elements
  typedef logic signed [15:0] result_t;

  // Rows and cols of one matrix
  typedef struct packed {
    logic [DIM_W-1:0] rows;
    logic [DIM_W-1:0] cols;
  } dims_t;

  // Location of one element in the store
  typedef struct packed {
    logic [SLOT_W-1:0] slot;
    logic [DIM_W-1:0]  row;
    logic [DIM_W-1:0]  col;
  } elem_addr_t;

endpackage
